/* dv/serial_bus_properties.sv */
`timescale 1ns/1ps

module serial_bus_properties (
    input logic clk,
    input logic rstN,
    input logic control,
    input logic valid,
    input logic last,
    input logic cmd_busy,
    input logic rd_finished
);

    // frame bits and write bits never share a cycle
    frame_vs_data: assert property (@(posedge clk) disable iff (!rstN) !(valid && control))
        else $error("valid and control high in the same cycle");

    // write data only inside an accepted command
    data_when_busy: assert property (@(posedge clk) disable iff (!rstN) valid |-> cmd_busy)
        else $error("valid high while the serializer is idle");

    // final bit closes the command
    // a write drops busy, a read sees the deserializer finish
    last_on_final_bit: assert property (@(posedge clk) disable iff (!rstN)
        $rose(last) |=> (!valid && (!cmd_busy || rd_finished)))
        else $error("last raised before the final bit of a command");

    // one cycle strobe
    last_is_pulse: assert property (@(posedge clk) disable iff (!rstN) last |=> !last)
        else $error("last held for more than one cycle");

endmodule

bind cmd_serializer serial_bus_properties u_props (
    .clk         (clk),
    .rstN        (rstN),
    .control     (control),
    .valid       (valid),
    .last        (last),
    .cmd_busy    (cmd_busy),
    .rd_finished (rd_finished)
);

/* dv/serial_bus_tb.sv */
`timescale 1ns/1ps

module serial_bus_tb;

    localparam int SLAVES       = 3;
    localparam int ADDR_DEPTH   = 64;
    localparam int DATA_WIDTH   = 8;
    localparam int MAX_BURST    = 8;
    localparam int ID_W         = $clog2(SLAVES + 1);
    localparam int ADDR_W       = $clog2(ADDR_DEPTH);
    localparam int LEN_W        = $clog2(MAX_BURST + 1);
    localparam int FRAME_BITS   = 3 + ID_W + 2 + ADDR_W;
    localparam int RESET_CYCLES = 16;
    localparam int MIX_CMDS     = 200;

    logic                    clk;
    logic                    rstN;
    logic                    cmd_valid;
    serial_bus_pkg::opcode_e cmd_op;
    logic [ID_W-1:0]         cmd_slave;
    logic [ADDR_W-1:0]       cmd_addr;
    logic [LEN_W-1:0]        cmd_len;
    logic [DATA_WIDTH-1:0]   wr_data;
    logic                    cmd_busy;
    logic                    wr_data_req;
    logic [DATA_WIDTH-1:0]   rd_data;
    logic                    rd_data_valid;
    logic                    rd_done;

    // expected memory per slave, x until written
    logic [DATA_WIDTH-1:0] model [SLAVES][ADDR_DEPTH];

    // random mix, drawn before the run so the budget covers it
    serial_bus_pkg::opcode_e mix_op [MIX_CMDS];
    int mix_slave [MIX_CMDS];
    int mix_addr  [MIX_CMDS];
    int mix_len   [MIX_CMDS];

    int data_errs   = 0;
    int done_errs   = 0;
    int other_errs  = 0;
    int cycles      = 0;
    int cycle_limit = 0;

    serial_bus_top #(
        .SLAVES     (SLAVES),
        .ADDR_DEPTH (ADDR_DEPTH),
        .DATA_WIDTH (DATA_WIDTH),
        .MAX_BURST  (MAX_BURST)
    ) UUT (
        .clk           (clk),
        .rstN          (rstN),
        .cmd_valid     (cmd_valid),
        .cmd_op        (cmd_op),
        .cmd_slave     (cmd_slave),
        .cmd_addr      (cmd_addr),
        .cmd_len       (cmd_len),
        .wr_data       (wr_data),
        .cmd_busy      (cmd_busy),
        .wr_data_req   (wr_data_req),
        .rd_data       (rd_data),
        .rd_data_valid (rd_data_valid),
        .rd_done       (rd_done)
    );

    // 20 ns period
    always #10 clk = ~clk;

    // run budget
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: run went past its budget of %0d cycles", cycle_limit);
            $display("errors: data %0d, done %0d, other %0d", data_errs, done_errs, other_errs);
            $display("sim failed");
            $finish;
        end
    end

    // inputs change 2 ns after the edge, outputs are settled by then
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    function automatic int cmd_cycles(input int len);
        return FRAME_BITS + len * DATA_WIDTH;
    endfunction

    task automatic check_word(input string test, input logic [DATA_WIDTH-1:0] exp,
                              input logic [DATA_WIDTH-1:0] act);
        if (act !== exp) begin
            data_errs++;
            $display("ERR %s: rd_data expected %h, actual %h", test, exp, act);
        end
    endtask

    task automatic check_done(input string test, input logic exp, input logic act);
        if (act !== exp) begin
            done_errs++;
            $display("ERR %s: rd_done expected %0b, actual %0b", test, exp, act);
        end
    endtask

    // one cycle command pulse
    task automatic issue(input serial_bus_pkg::opcode_e op, input int slave, input int addr,
                         input int len);
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_slave = ID_W'(slave);
        cmd_addr  = ADDR_W'(addr);
        cmd_len   = LEN_W'(len);
        step();
        cmd_valid = 1'b0;
    endtask

    // intr_slave above 0 pulses a second command mid frame
    task automatic do_write(input string test, input int slave, input int addr, input int len,
                            input int intr_slave, input int intr_addr);
        logic [DATA_WIDTH-1:0] words [MAX_BURST];
        int n;
        int k;
        for (k = 0; k < len; k++) begin
            words[k] = DATA_WIDTH'($urandom);
        end
        n = 0;
        k = 0;
        issue(serial_bus_pkg::OP_WRITE, slave, addr, len);
        while (cmd_busy) begin
            // word goes on wr_data for the cycle after the request
            if (wr_data_req) begin
                if (n < len) begin
                    wr_data = words[n];
                end
                n++;
            end
            cmd_valid = 1'b0;
            if (intr_slave > 0 && k == 4) begin
                cmd_valid = 1'b1;
                cmd_slave = ID_W'(intr_slave);
                cmd_addr  = ADDR_W'(intr_addr);
                cmd_len   = LEN_W'(1);
            end
            k++;
            step();
        end
        cmd_valid = 1'b0;
        // busy spans the frame and the data bits, then drops
        if (k != cmd_cycles(len)) begin
            other_errs++;
            $display("ERR %s: cmd_busy cycles expected %0d, actual %0d", test,
                     cmd_cycles(len), k);
        end
        if (n != len) begin
            other_errs++;
            $display("%s: write of %0d words made %0d data requests", test, len, n);
        end
        // id 0 reaches no slave
        if (slave >= 1 && slave <= SLAVES) begin
            for (k = 0; k < len; k++) begin
                model[slave-1][addr+k] = words[k];
            end
        end
    endtask

    task automatic do_read(input string test, input int slave, input int addr, input int len);
        logic [DATA_WIDTH-1:0] exp;
        logic                  late;
        int n;
        n    = 0;
        late = 1'b0;
        issue(serial_bus_pkg::OP_READ, slave, addr, len);
        while (cmd_busy) begin
            // busy drops the cycle after rd_done
            if (n >= len && !late) begin
                late = 1'b1;
                other_errs++;
                $display("%s: cmd_busy still high after the last word", test);
            end
            if (rd_data_valid) begin
                if (n < len) begin
                    exp = model[slave-1][addr+n];
                    // only words already written are known
                    if (!$isunknown(exp)) begin
                        check_word(test, exp, rd_data);
                    end
                    check_done(test, n == len - 1, rd_done);
                end
                n++;
            end else if (rd_done) begin
                other_errs++;
                $display("%s: rd_done came without a word", test);
            end
            step();
        end
        if (n != len) begin
            other_errs++;
            $display("%s: read of %0d words ended with %0d rd_data_valid pulses", test, len, n);
        end
    endtask

    initial begin
        int burst_len;
        int bits;
        int addr;
        int i;
        clk       = 1'b0;
        rstN      = 1'b0;
        cmd_valid = 1'b0;
        cmd_op    = serial_bus_pkg::OP_READ;
        cmd_slave = '0;
        cmd_addr  = '0;
        cmd_len   = '0;
        wr_data   = '0;
        for (int s = 0; s < SLAVES; s++) begin
            for (int a = 0; a < ADDR_DEPTH; a++) begin
                model[s][a] = 'x;
            end
        end
        void'($urandom(32'h25bc_e196));

        // budget: directed commands plus the random mix
        burst_len = 2 + int'($urandom % (MAX_BURST - 1));
        bits = (2 + 2 * SLAVES + 1 + 4) * cmd_cycles(1) + 2 * cmd_cycles(burst_len);
        for (i = 0; i < MIX_CMDS; i++) begin
            mix_op[i]    = ($urandom % 2) ? serial_bus_pkg::OP_WRITE : serial_bus_pkg::OP_READ;
            mix_slave[i] = 1 + int'($urandom % SLAVES);
            mix_len[i]   = 1 + int'($urandom % MAX_BURST);
            mix_addr[i]  = int'($urandom % (ADDR_DEPTH - mix_len[i] + 1));
            bits += cmd_cycles(mix_len[i]);
        end
        cycle_limit = bits * 3 / 2 + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rstN = 1'b1;
        step();

        // single word round trip
        addr = int'($urandom % ADDR_DEPTH);
        do_write("single", 1, addr, 1, 0, 0);
        do_read("single", 1, addr, 1);

        // burst round trip, words in address order
        addr = int'($urandom % (ADDR_DEPTH - burst_len + 1));
        do_write("burst", 2, addr, burst_len, 0, 0);
        do_read("burst", 2, addr, burst_len);

        // same address per slave, then a frame to id 0
        addr = int'($urandom % ADDR_DEPTH);
        for (i = 1; i <= SLAVES; i++) begin
            do_write("isolation", i, addr, 1, 0, 0);
        end
        do_write("isolation", 0, addr, 1, 0, 0);
        for (i = 1; i <= SLAVES; i++) begin
            do_read("isolation", i, addr, 1);
        end

        // second command while busy must leave slave 2 alone
        addr = int'($urandom % ADDR_DEPTH);
        do_write("busy_drop", 2, addr, 1, 0, 0);
        do_write("busy_drop", 1, addr ^ 1, 1, 2, addr);
        do_read("busy_drop", 2, addr, 1);
        do_read("busy_drop", 1, addr ^ 1, 1);

        for (i = 0; i < MIX_CMDS; i++) begin
            if (mix_op[i] == serial_bus_pkg::OP_WRITE) begin
                do_write("random_mix", mix_slave[i], mix_addr[i], mix_len[i], 0, 0);
            end else begin
                do_read("random_mix", mix_slave[i], mix_addr[i], mix_len[i]);
            end
        end

        $display("errors: data %0d, done %0d, other %0d", data_errs, done_errs, other_errs);
        if (data_errs + done_errs + other_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* list.f */
source/serial_bus_pkg.sv
source/cmd_serializer.sv
source/serial_mem_slave.sv
source/read_deserializer.sv
source/serial_bus_top.sv
dv/serial_bus_properties.sv
dv/serial_bus_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the serial bus testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module serial_bus_tb \
    -f list.f -o serial_bus_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/serial_bus_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0

/* source/cmd_serializer.sv */
`timescale 1ns/1ps

module cmd_serializer #(
    parameter int SLAVES     = 3,
    parameter int ADDR_DEPTH = 64,
    parameter int DATA_WIDTH = 8,
    parameter int MAX_BURST  = 8,
    localparam int ID_W      = $clog2(SLAVES + 1),
    localparam int ADDR_W    = $clog2(ADDR_DEPTH),
    localparam int LEN_W     = $clog2(MAX_BURST + 1)
) (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    cmd_valid,
    input  serial_bus_pkg::opcode_e cmd_op,
    input  logic [ID_W-1:0]         cmd_slave,
    input  logic [ADDR_W-1:0]       cmd_addr,
    input  logic [LEN_W-1:0]        cmd_len,
    input  logic [DATA_WIDTH-1:0]   wr_data,
    input  logic                    rd_finished,
    output logic                    cmd_busy,
    output logic                    wr_data_req,
    output logic                    control,
    output logic                    wD,
    output logic                    valid,
    output logic                    last,
    output logic [ID_W-1:0]         sel_slave,
    output logic                    rd_start
);

    // start | id | r/w | burst | address
    localparam int FRAME_BITS = 3 + ID_W + 2 + ADDR_W;
    // frame bit index, later the read cycle count
    localparam int CNT_W      = $clog2(FRAME_BITS + MAX_BURST * DATA_WIDTH + 2);
    localparam int BIT_W      = $clog2(DATA_WIDTH);

    serial_bus_pkg::ser_state_e state;
    serial_bus_pkg::opcode_e    op_r;

    logic [LEN_W-1:0]      len_r;
    logic [FRAME_BITS-1:0] frame_sr;
    logic [CNT_W-1:0]      cnt;
    logic [CNT_W-1:0]      rd_bits;
    logic [BIT_W-1:0]      bit_cnt;
    logic [LEN_W-1:0]      word_cnt;
    logic [DATA_WIDTH-1:0] word_sr;
    logic [DATA_WIDTH-1:0] cur_word;
    logic                  frame_end;
    logic                  word_end;
    logic                  last_word;

    assign frame_end = (state == serial_bus_pkg::SER_FRAME) && (cnt == CNT_W'(FRAME_BITS - 1));
    assign word_end  = (state == serial_bus_pkg::SER_WDATA) && (bit_cnt == BIT_W'(DATA_WIDTH - 1));
    assign last_word = (word_cnt == len_r - 1'b1);

    // slave read stream starts two cycles after the frame, gapless
    assign rd_bits = CNT_W'(len_r * DATA_WIDTH);

    // first bit of a word comes straight from the user
    assign cur_word = (bit_cnt == '0) ? wr_data : word_sr;

    assign cmd_busy = (state != serial_bus_pkg::SER_IDLE);
    assign control  = (state == serial_bus_pkg::SER_FRAME) && frame_sr[FRAME_BITS-1];
    assign valid    = (state == serial_bus_pkg::SER_WDATA);
    assign wD       = valid && cur_word[DATA_WIDTH-1];
    assign rd_start = frame_end && (op_r == serial_bus_pkg::OP_READ);

    // request one cycle ahead of each word
    assign wr_data_req = (frame_end && (op_r == serial_bus_pkg::OP_WRITE)) ||
                         (word_end && !last_word);

    // write: final bit of final word; read: counted from cmd_len
    assign last = (word_end && last_word) ||
                  ((state == serial_bus_pkg::SER_RWAIT) && (cnt == rd_bits));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= serial_bus_pkg::SER_IDLE;
            op_r      <= serial_bus_pkg::OP_READ;
            len_r     <= '0;
            sel_slave <= '0;
            cnt       <= '0;
            bit_cnt   <= '0;
            word_cnt  <= '0;
        end else begin
            case (state)
                serial_bus_pkg::SER_IDLE: begin
                    // busy is low only here, so this is the accept
                    if (cmd_valid) begin
                        op_r      <= cmd_op;
                        len_r     <= cmd_len;
                        sel_slave <= cmd_slave;
                        cnt       <= '0;
                        state     <= serial_bus_pkg::SER_FRAME;
                    end
                end
                serial_bus_pkg::SER_FRAME: begin
                    cnt <= cnt + 1'b1;
                    if (frame_end) begin
                        cnt      <= '0;
                        bit_cnt  <= '0;
                        word_cnt <= '0;
                        if (op_r == serial_bus_pkg::OP_WRITE) begin
                            state <= serial_bus_pkg::SER_WDATA;
                        end else begin
                            state <= serial_bus_pkg::SER_RWAIT;
                        end
                    end
                end
                serial_bus_pkg::SER_WDATA: begin
                    if (word_end) begin
                        bit_cnt  <= '0;
                        word_cnt <= word_cnt + 1'b1;
                        if (last_word) begin
                            state <= serial_bus_pkg::SER_IDLE;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                serial_bus_pkg::SER_RWAIT: begin
                    cnt <= cnt + 1'b1;
                    // deserializer has the last word
                    if (rd_finished) begin
                        state <= serial_bus_pkg::SER_IDLE;
                    end
                end
                default: state <= serial_bus_pkg::SER_IDLE;
            endcase
        end
    end

    // frame and word shifters
    always_ff @(posedge clk) begin
        if (state == serial_bus_pkg::SER_IDLE && cmd_valid) begin
            frame_sr <= {serial_bus_pkg::START_CODE, cmd_slave, cmd_op,
                         cmd_len > LEN_W'(1), cmd_addr};
        end else if (state == serial_bus_pkg::SER_FRAME) begin
            frame_sr <= frame_sr << 1;
        end
        if (valid) begin
            word_sr <= cur_word << 1;
        end
    end

endmodule

/* source/read_deserializer.sv */
`timescale 1ns/1ps

module read_deserializer #(
    parameter int SLAVES     = 3,
    parameter int DATA_WIDTH = 8,
    localparam int ID_W      = $clog2(SLAVES + 1)
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic [SLAVES-1:0]     rD,
    input  logic [SLAVES-1:0]     ready,
    input  logic [ID_W-1:0]       sel_slave,
    input  logic                  rd_start,
    input  logic                  last,
    output logic [DATA_WIDTH-1:0] rd_data,
    output logic                  rd_data_valid,
    output logic                  rd_done,
    output logic                  rd_finished
);

    localparam int BIT_W = $clog2(DATA_WIDTH);

    logic                  active;
    logic [BIT_W-1:0]      bit_cnt;
    logic [DATA_WIDTH-1:0] shift_sr;
    logic                  sel_rd;
    logic                  sel_ready;
    logic                  take;
    logic                  word_end;

    // slave ids start at 1, id 0 selects nothing
    always_comb begin
        sel_rd    = 1'b0;
        sel_ready = 1'b0;
        for (int i = 0; i < SLAVES; i++) begin
            if (sel_slave == ID_W'(i + 1)) begin
                sel_rd    = rD[i];
                sel_ready = ready[i];
            end
        end
    end

    assign take     = active && sel_ready;
    assign word_end = take && (bit_cnt == BIT_W'(DATA_WIDTH - 1));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            active        <= 1'b0;
            bit_cnt       <= '0;
            rd_data_valid <= 1'b0;
            rd_done       <= 1'b0;
            rd_finished   <= 1'b0;
        end else begin
            rd_data_valid <= 1'b0;
            rd_done       <= 1'b0;
            rd_finished   <= 1'b0;
            if (rd_start) begin
                active  <= 1'b1;
                bit_cnt <= '0;
            end else if (word_end) begin
                bit_cnt       <= '0;
                rd_data_valid <= 1'b1;
                if (last) begin
                    rd_done     <= 1'b1;
                    rd_finished <= 1'b1;
                    active      <= 1'b0;
                end
            end else if (take) begin
                bit_cnt <= bit_cnt + 1'b1;
            end else if (active && last) begin
                // no slave answered, release the serializer
                rd_finished <= 1'b1;
                active      <= 1'b0;
            end
        end
    end

    // word assembly, MSB first
    always_ff @(posedge clk) begin
        if (take) begin
            shift_sr <= {shift_sr[DATA_WIDTH-2:0], sel_rd};
        end
        if (word_end) begin
            rd_data <= {shift_sr[DATA_WIDTH-2:0], sel_rd};
        end
    end

endmodule

/* source/serial_bus_pkg.sv */
package serial_bus_pkg;

    // every frame opens with three ones
    localparam logic [2:0] START_CODE = 3'b111;

    // matches the read/write bit of the frame
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } opcode_e;

    // command serializer FSM
    typedef enum logic [1:0] {
        SER_IDLE,
        SER_FRAME,
        SER_WDATA,
        SER_RWAIT
    } ser_state_e;

    // memory slave FSM
    typedef enum logic [2:0] {
        IDLE,
        CONFIG,
        CONFIG2,
        READ,
        READB,
        WRITE,
        WRITEB
    } slv_state_e;

endpackage

/* source/serial_bus_top.sv */
`timescale 1ns/1ps

module serial_bus_top #(
    parameter int SLAVES     = 3,
    parameter int ADDR_DEPTH = 64,
    parameter int DATA_WIDTH = 8,
    parameter int MAX_BURST  = 8,
    localparam int ID_W      = $clog2(SLAVES + 1),
    localparam int ADDR_W    = $clog2(ADDR_DEPTH),
    localparam int LEN_W     = $clog2(MAX_BURST + 1)
) (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    cmd_valid,
    input  serial_bus_pkg::opcode_e cmd_op,
    input  logic [ID_W-1:0]         cmd_slave,
    input  logic [ADDR_W-1:0]       cmd_addr,
    input  logic [LEN_W-1:0]        cmd_len,
    input  logic [DATA_WIDTH-1:0]   wr_data,
    output logic                    cmd_busy,
    output logic                    wr_data_req,
    output logic [DATA_WIDTH-1:0]   rd_data,
    output logic                    rd_data_valid,
    output logic                    rd_done
);

    // broadcast lines
    logic control;
    logic wD;
    logic valid;
    logic last;

    // per slave return lines
    logic [SLAVES-1:0] rD;
    logic [SLAVES-1:0] ready;

    logic [ID_W-1:0] sel_slave;
    logic            rd_start;
    logic            rd_finished;

    cmd_serializer #(
        .SLAVES     (SLAVES),
        .ADDR_DEPTH (ADDR_DEPTH),
        .DATA_WIDTH (DATA_WIDTH),
        .MAX_BURST  (MAX_BURST)
    ) u_ser (
        .clk         (clk),
        .rstN        (rstN),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_slave   (cmd_slave),
        .cmd_addr    (cmd_addr),
        .cmd_len     (cmd_len),
        .wr_data     (wr_data),
        .rd_finished (rd_finished),
        .cmd_busy    (cmd_busy),
        .wr_data_req (wr_data_req),
        .control     (control),
        .wD          (wD),
        .valid       (valid),
        .last        (last),
        .sel_slave   (sel_slave),
        .rd_start    (rd_start)
    );

    // slave ids run 1 to SLAVES
    for (genvar i = 0; i < SLAVES; i++) begin : g_slave
        serial_mem_slave #(
            .SLAVES     (SLAVES),
            .ADDR_DEPTH (ADDR_DEPTH),
            .DATA_WIDTH (DATA_WIDTH),
            .SLAVEID    (i + 1)
        ) u_slave (
            .clk     (clk),
            .rstN    (rstN),
            .control (control),
            .wD      (wD),
            .valid   (valid),
            .last    (last),
            .rD      (rD[i]),
            .ready   (ready[i])
        );
    end

    read_deserializer #(
        .SLAVES     (SLAVES),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_deser (
        .clk           (clk),
        .rstN          (rstN),
        .rD            (rD),
        .ready         (ready),
        .sel_slave     (sel_slave),
        .rd_start      (rd_start),
        .last          (last),
        .rd_data       (rd_data),
        .rd_data_valid (rd_data_valid),
        .rd_done       (rd_done),
        .rd_finished   (rd_finished)
    );

endmodule

/* source/serial_mem_slave.sv */
`timescale 1ns/1ps

module serial_mem_slave #(
    parameter int SLAVES     = 3,
    parameter int ADDR_DEPTH = 64,
    parameter int DATA_WIDTH = 8,
    parameter int SLAVEID    = 1,
    localparam int ID_W      = $clog2(SLAVES + 1),
    localparam int ADDR_W    = $clog2(ADDR_DEPTH)
) (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic wD,
    input  logic valid,
    input  logic last,
    output logic rD,
    output logic ready
);

    localparam int FRAME_BITS = 3 + ID_W + 2 + ADDR_W;
    localparam int FCNT_W     = $clog2(FRAME_BITS);
    localparam int BIT_W      = $clog2(DATA_WIDTH);

    serial_bus_pkg::slv_state_e state;

    logic [FRAME_BITS-1:0] cfg_sr;
    logic [FCNT_W-1:0]     fcnt;
    logic [BIT_W-1:0]      bit_cnt;
    logic [ADDR_W-1:0]     addr;
    logic [ADDR_W-1:0]     next_addr;
    logic [DATA_WIDTH-1:0] data_sr;
    logic [DATA_WIDTH-1:0] ram [ADDR_DEPTH];

    logic frame_ok;
    logic is_write;
    logic is_burst;
    logic wr_bit;
    logic word_end;

    // frame fields, MSB first
    assign frame_ok = (cfg_sr[FRAME_BITS-1 -: 3] == serial_bus_pkg::START_CODE) &&
                      (cfg_sr[ADDR_W+2 +: ID_W] == ID_W'(SLAVEID));
    assign is_write = cfg_sr[ADDR_W+1];
    assign is_burst = cfg_sr[ADDR_W];

    assign next_addr = addr + 1'b1;

    // read bit on the line while in a read state
    assign ready  = (state == serial_bus_pkg::READ) || (state == serial_bus_pkg::READB);
    assign rD     = ready && data_sr[DATA_WIDTH-1];
    assign wr_bit = valid &&
                    ((state == serial_bus_pkg::WRITE) || (state == serial_bus_pkg::WRITEB));

    // final bit of a word in either direction
    assign word_end = (ready || wr_bit) && (bit_cnt == BIT_W'(DATA_WIDTH - 1));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= serial_bus_pkg::IDLE;
            cfg_sr  <= '0;
            fcnt    <= '0;
            bit_cnt <= '0;
            addr    <= '0;
        end else begin
            case (state)
                serial_bus_pkg::IDLE: begin
                    // first frame bit is always one
                    if (control) begin
                        cfg_sr <= {cfg_sr[FRAME_BITS-2:0], control};
                        fcnt   <= FCNT_W'(1);
                        state  <= serial_bus_pkg::CONFIG;
                    end
                end
                serial_bus_pkg::CONFIG: begin
                    cfg_sr <= {cfg_sr[FRAME_BITS-2:0], control};
                    fcnt   <= fcnt + 1'b1;
                    if (fcnt == FCNT_W'(FRAME_BITS - 1)) begin
                        state <= serial_bus_pkg::CONFIG2;
                    end
                end
                serial_bus_pkg::CONFIG2: begin
                    // first write bit is already on wD here
                    addr    <= cfg_sr[ADDR_W-1:0];
                    bit_cnt <= '0;
                    if (!frame_ok) begin
                        state <= serial_bus_pkg::IDLE;
                    end else if (is_write) begin
                        bit_cnt <= BIT_W'(1);
                        state   <= is_burst ? serial_bus_pkg::WRITEB : serial_bus_pkg::WRITE;
                    end else begin
                        state <= is_burst ? serial_bus_pkg::READB : serial_bus_pkg::READ;
                    end
                end
                serial_bus_pkg::READ, serial_bus_pkg::READB,
                serial_bus_pkg::WRITE, serial_bus_pkg::WRITEB: begin
                    if (word_end) begin
                        bit_cnt <= '0;
                        // single word, or burst closed by last
                        if (state == serial_bus_pkg::READ || state == serial_bus_pkg::WRITE ||
                            last) begin
                            state <= serial_bus_pkg::IDLE;
                        end else begin
                            addr <= next_addr;
                        end
                    end else if (ready || wr_bit) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= serial_bus_pkg::IDLE;
            endcase
        end
    end

    // word memory and data shifter
    always_ff @(posedge clk) begin
        if (state == serial_bus_pkg::CONFIG2 && frame_ok) begin
            if (is_write) begin
                data_sr <= {data_sr[DATA_WIDTH-2:0], wD};
            end else begin
                data_sr <= ram[cfg_sr[ADDR_W-1:0]];
            end
        end else if (wr_bit) begin
            data_sr <= {data_sr[DATA_WIDTH-2:0], wD};
            // commit with the word's final bit
            if (word_end) begin
                ram[addr] <= {data_sr[DATA_WIDTH-2:0], wD};
            end
        end else if (ready) begin
            // burst reload keeps the stream gapless
            if (word_end) begin
                data_sr <= ram[next_addr];
            end else begin
                data_sr <= data_sr << 1;
            end
        end
    end

endmodule
